//--- rv_pkg.sv
package rv_pkg;

  // datapath geometry
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;

  localparam logic [XLEN-1:0] PC_STEP  = 32'd4;
  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

  // major opcodes handled by the core
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_BRANCH = 7'b1100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // funct3 of the arithmetic groups, shared by OP and OP-IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct3 of the conditional branches
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // funct7 values, alt selects SUB and SRA/SRAI
  localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
  localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } insn_r_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } insn_i_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } insn_s_t;

  // branch offset bits are scattered around the register fields
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } insn_b_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } insn_u_t;

  // one instruction word, seen through each encoding format
  typedef union packed {
    insn_r_t r;
    insn_i_t i;
    insn_s_t s;
    insn_b_t b;
    insn_u_t u;
  } insn_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B,
    ALU_PC_PLUS_B
  } alu_op_e;

  // encoded as the branch funct3
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } branch_op_e;

  typedef struct packed {
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       imm;
    alu_op_e               alu_op;
    logic                  use_imm;
    logic                  rd_we;
    logic                  is_branch;
    branch_op_e            branch_op;
    logic                  is_halt;
  } decoded_t;

  // record of one retired instruction
  typedef struct packed {
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       next_pc;
    logic                  rd_we;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       rd_data;
  } commit_t;

endpackage

//--- rv_decoder.sv
module rv_decoder (
  input  rv_pkg::insn_t    i_insn,
  output rv_pkg::decoded_t o_dec
);

  logic [rv_pkg::XLEN-1:0] imm_i;
  logic [rv_pkg::XLEN-1:0] imm_b;
  logic [rv_pkg::XLEN-1:0] imm_u;
  logic                    is_op;
  logic                    f7_base;
  logic                    f7_alt;
  logic                    op_ok;
  logic                    imm_ok;
  rv_pkg::alu_op_e         arith_op;

  // immediates, sign-extended from the matching format
  assign imm_i = {{20{i_insn.i.imm[11]}}, i_insn.i.imm};
  assign imm_b = {{20{i_insn.b.imm_12}}, i_insn.b.imm_11, i_insn.b.imm_10_5,
                  i_insn.b.imm_4_1, 1'b0};
  assign imm_u = {i_insn.u.imm, 12'b0};

  assign is_op   = i_insn.r.opcode == rv_pkg::OPC_OP;
  assign f7_base = i_insn.r.funct7 == rv_pkg::FUNCT7_BASE;
  assign f7_alt  = i_insn.r.funct7 == rv_pkg::FUNCT7_ALT;

  // register-register form: alt funct7 only for SUB and SRA
  assign op_ok = f7_base ||
                 (f7_alt && (i_insn.r.funct3 == rv_pkg::F3_ADD_SUB ||
                             i_insn.r.funct3 == rv_pkg::F3_SRL_SRA));

  // immediate form: funct7 only constrains the shifts
  always_comb
  begin
    case (i_insn.r.funct3)
      rv_pkg::F3_SLL:     imm_ok = f7_base;
      rv_pkg::F3_SRL_SRA: imm_ok = f7_base || f7_alt;
      default:            imm_ok = 1'b1;
    endcase
  end

  // funct3 to ALU op, common to OP and OP-IMM
  always_comb
  begin
    case (i_insn.r.funct3)
      rv_pkg::F3_ADD_SUB: arith_op = (is_op && f7_alt) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      rv_pkg::F3_SLL:     arith_op = rv_pkg::ALU_SLL;
      rv_pkg::F3_SLT:     arith_op = rv_pkg::ALU_SLT;
      rv_pkg::F3_SLTU:    arith_op = rv_pkg::ALU_SLTU;
      rv_pkg::F3_XOR:     arith_op = rv_pkg::ALU_XOR;
      rv_pkg::F3_SRL_SRA: arith_op = f7_alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      rv_pkg::F3_OR:      arith_op = rv_pkg::ALU_OR;
      rv_pkg::F3_AND:     arith_op = rv_pkg::ALU_AND;
      default:            arith_op = rv_pkg::ALU_ADD;
    endcase
  end

  always_comb
  begin
    // anything unmatched falls through as a plain pc+4 no-op
    o_dec           = '0;
    o_dec.rs1       = i_insn.r.rs1;
    o_dec.rs2       = i_insn.r.rs2;
    o_dec.rd        = i_insn.r.rd;
    o_dec.alu_op    = rv_pkg::ALU_ADD;
    o_dec.branch_op = rv_pkg::BR_EQ;

    case (i_insn.r.opcode)
      rv_pkg::OPC_LUI:
      begin
        o_dec.imm     = imm_u;
        o_dec.use_imm = 1'b1;
        o_dec.alu_op  = rv_pkg::ALU_PASS_B;
        o_dec.rd_we   = 1'b1;
      end
      rv_pkg::OPC_AUIPC:
      begin
        o_dec.imm     = imm_u;
        o_dec.use_imm = 1'b1;
        o_dec.alu_op  = rv_pkg::ALU_PC_PLUS_B;
        o_dec.rd_we   = 1'b1;
      end
      rv_pkg::OPC_OP_IMM:
      begin
        if (imm_ok)
        begin
          o_dec.imm     = imm_i;
          o_dec.use_imm = 1'b1;
          o_dec.alu_op  = arith_op;
          o_dec.rd_we   = 1'b1;
        end
      end
      rv_pkg::OPC_OP:
      begin
        if (op_ok)
        begin
          o_dec.alu_op = arith_op;
          o_dec.rd_we  = 1'b1;
        end
      end
      rv_pkg::OPC_BRANCH:
      begin
        case (i_insn.b.funct3)
          rv_pkg::F3_BEQ, rv_pkg::F3_BNE, rv_pkg::F3_BLT,
          rv_pkg::F3_BGE, rv_pkg::F3_BLTU, rv_pkg::F3_BGEU:
          begin
            o_dec.imm       = imm_b;
            o_dec.is_branch = 1'b1;
            o_dec.branch_op = rv_pkg::branch_op_e'(i_insn.b.funct3);
          end
          default:
          begin
          end
        endcase
      end
      rv_pkg::OPC_SYSTEM:
      begin
        // only the all-zero ECALL form halts
        o_dec.is_halt = {i_insn.i.imm, i_insn.i.rs1, i_insn.i.funct3, i_insn.i.rd} == '0;
      end
      default:
      begin
      end
    endcase
  end

endmodule

//--- rv_regfile.sv
module rv_regfile (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [rv_pkg::REG_ADDR_W-1:0] i_rs1_addr,
  input  logic [rv_pkg::REG_ADDR_W-1:0] i_rs2_addr,
  input  logic [rv_pkg::REG_ADDR_W-1:0] i_rd_addr,
  input  logic                          i_rd_we,
  input  logic [rv_pkg::XLEN-1:0]       i_rd_data,
  output logic [rv_pkg::XLEN-1:0]       o_rs1_data,
  output logic [rv_pkg::XLEN-1:0]       o_rs2_data
);

  logic [rv_pkg::XLEN-1:0] regs [rv_pkg::NUM_REGS];

  // x0 is never written
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < rv_pkg::NUM_REGS; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (i_rd_we && (i_rd_addr != '0))
    begin
      regs[i_rd_addr] <= i_rd_data;
    end
  end

  // combinational reads see the value before this cycle's write
  assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
  assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

endmodule

//--- rv_alu.sv
module rv_alu (
  input  rv_pkg::alu_op_e         i_op,
  input  logic [rv_pkg::XLEN-1:0] i_src_a,
  input  logic [rv_pkg::XLEN-1:0] i_src_b,
  input  logic [rv_pkg::XLEN-1:0] i_pc,
  output logic [rv_pkg::XLEN-1:0] o_result
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // shifts only look at the low five bits
  assign shamt = i_src_b[4:0];

  assign lt_signed   = $signed(i_src_a) < $signed(i_src_b);
  assign lt_unsigned = i_src_a < i_src_b;

  always_comb
  begin
    case (i_op)
      rv_pkg::ALU_ADD:
      begin
        o_result = i_src_a + i_src_b;
      end
      rv_pkg::ALU_SUB:
      begin
        o_result = i_src_a - i_src_b;
      end
      rv_pkg::ALU_SLL:
      begin
        o_result = i_src_a << shamt;
      end
      rv_pkg::ALU_SLT:
      begin
        o_result = {{(rv_pkg::XLEN-1){1'b0}}, lt_signed};
      end
      rv_pkg::ALU_SLTU:
      begin
        o_result = {{(rv_pkg::XLEN-1){1'b0}}, lt_unsigned};
      end
      rv_pkg::ALU_XOR:
      begin
        o_result = i_src_a ^ i_src_b;
      end
      rv_pkg::ALU_SRL:
      begin
        o_result = i_src_a >> shamt;
      end
      rv_pkg::ALU_SRA:
      begin
        // sign fill from bit 31
        o_result = $unsigned($signed(i_src_a) >>> shamt);
      end
      rv_pkg::ALU_OR:
      begin
        o_result = i_src_a | i_src_b;
      end
      rv_pkg::ALU_AND:
      begin
        o_result = i_src_a & i_src_b;
      end
      // lui
      rv_pkg::ALU_PASS_B:
      begin
        o_result = i_src_b;
      end
      // auipc
      rv_pkg::ALU_PC_PLUS_B:
      begin
        o_result = i_pc + i_src_b;
      end
      default:
      begin
        o_result = '0;
      end
    endcase
  end

endmodule

//--- rv_branch_unit.sv
module rv_branch_unit (
  input  logic                    i_is_branch,
  input  rv_pkg::branch_op_e      i_branch_op,
  input  logic [rv_pkg::XLEN-1:0] i_rs1_data,
  input  logic [rv_pkg::XLEN-1:0] i_rs2_data,
  input  logic [rv_pkg::XLEN-1:0] i_imm,
  input  logic [rv_pkg::XLEN-1:0] i_pc,
  output logic [rv_pkg::XLEN-1:0] o_next_pc
);

  logic eq;
  logic lt_signed;
  logic lt_unsigned;
  logic taken;

  assign eq          = i_rs1_data == i_rs2_data;
  assign lt_signed   = $signed(i_rs1_data) < $signed(i_rs2_data);
  assign lt_unsigned = i_rs1_data < i_rs2_data;

  // ge conditions are the inverse of lt
  always_comb
  begin
    case (i_branch_op)
      rv_pkg::BR_EQ:  taken = eq;
      rv_pkg::BR_NE:  taken = !eq;
      rv_pkg::BR_LT:  taken = lt_signed;
      rv_pkg::BR_GE:  taken = !lt_signed;
      rv_pkg::BR_LTU: taken = lt_unsigned;
      rv_pkg::BR_GEU: taken = !lt_unsigned;
      default:        taken = 1'b0;
    endcase
  end

  // target is pc relative
  assign o_next_pc = (i_is_branch && taken) ? i_pc + i_imm : i_pc + rv_pkg::PC_STEP;

endmodule

//--- rv_core.sv
module rv_core (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    i_insn_valid,
  input  rv_pkg::insn_t           i_insn,
  output logic                    o_insn_ready,
  output logic [rv_pkg::XLEN-1:0] o_pc,
  output logic                    o_commit_valid,
  output rv_pkg::commit_t         o_commit,
  output logic                    o_halt
);

  logic [rv_pkg::XLEN-1:0] pc_q;
  logic                    halt_q;
  logic                    accept;
  logic                    rd_we;
  rv_pkg::decoded_t        dec;
  logic [rv_pkg::XLEN-1:0] rs1_data;
  logic [rv_pkg::XLEN-1:0] rs2_data;
  logic [rv_pkg::XLEN-1:0] alu_src_b;
  logic [rv_pkg::XLEN-1:0] alu_result;
  logic [rv_pkg::XLEN-1:0] next_pc;

  // fetch handshake, closed for good once halted
  assign o_insn_ready = !halt_q;
  assign accept       = i_insn_valid && o_insn_ready;

  // writeback only for an accepted instruction
  assign rd_we = accept && dec.rd_we;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc_q   <= rv_pkg::RESET_PC;
      halt_q <= 1'b0;
    end
    else if (accept)
    begin
      pc_q <= next_pc;
      if (dec.is_halt)
      begin
        halt_q <= 1'b1;
      end
    end
  end

  rv_decoder u_decoder (
    .i_insn (i_insn),
    .o_dec  (dec)
  );

  rv_regfile u_regfile (
    .clk        (clk),
    .rst        (rst),
    .i_rs1_addr (dec.rs1),
    .i_rs2_addr (dec.rs2),
    .i_rd_addr  (dec.rd),
    .i_rd_we    (rd_we),
    .i_rd_data  (alu_result),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  // immediate or rs2 as second operand
  assign alu_src_b = dec.use_imm ? dec.imm : rs2_data;

  rv_alu u_alu (
    .i_op     (dec.alu_op),
    .i_src_a  (rs1_data),
    .i_src_b  (alu_src_b),
    .i_pc     (pc_q),
    .o_result (alu_result)
  );

  rv_branch_unit u_branch_unit (
    .i_is_branch (dec.is_branch),
    .i_branch_op (dec.branch_op),
    .i_rs1_data  (rs1_data),
    .i_rs2_data  (rs2_data),
    .i_imm       (dec.imm),
    .i_pc        (pc_q),
    .o_next_pc   (next_pc)
  );

  // retire record, valid in the accepting cycle
  always_comb
  begin
    o_commit.pc      = pc_q;
    o_commit.next_pc = next_pc;
    o_commit.rd_we   = rd_we;
    o_commit.rd      = dec.rd;
    o_commit.rd_data = alu_result;
  end

  assign o_commit_valid = accept;
  assign o_pc           = pc_q;
  assign o_halt         = halt_q;

endmodule

//--- tb_rv_core.sv
module tb_rv_core;

  localparam int          NUM_INSNS  = 2000;
  localparam int          WAIT_LIMIT = 100;
  localparam int          HALT_HOLD  = 20;
  localparam logic [31:0] SEED       = 32'h8474e435;

  // instruction groups of the generator
  localparam int G_LUI    = 0;
  localparam int G_AUIPC  = 1;
  localparam int G_OPIMM  = 2;
  localparam int G_OP     = 3;
  localparam int G_BRANCH = 4;
  localparam int G_ECALL  = 5;

  logic            clk;
  logic            rst;
  logic            i_insn_valid;
  rv_pkg::insn_t   i_insn;
  logic            o_insn_ready;
  logic [31:0]     o_pc;
  logic            o_commit_valid;
  rv_pkg::commit_t o_commit;
  logic            o_halt;

  // architectural model state
  logic [31:0] mregs [32];
  logic [31:0] mpc;
  logic        mhalt;

  // fields of the instruction currently offered
  int          cur_grp;
  logic [2:0]  cur_f3;
  logic        cur_alt;
  logic [4:0]  cur_rd;
  logic [4:0]  cur_rs1;
  logic [4:0]  cur_rs2;
  logic [31:0] cur_imm;

  logic [2:0] br_f3 [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};

  rv_core DUT (
    .clk            (clk),
    .rst            (rst),
    .i_insn_valid   (i_insn_valid),
    .i_insn         (i_insn),
    .o_insn_ready   (o_insn_ready),
    .o_pc           (o_pc),
    .o_commit_valid (o_commit_valid),
    .o_commit       (o_commit),
    .o_halt         (o_halt)
  );

  always #5 clk = ~clk;

  task automatic stop_with_failure();
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
    $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
    stop_with_failure();
  endtask

  task automatic report_timeout(string what);
    $display("timeout: %s did not happen within %0d cycles", what, WAIT_LIMIT);
    stop_with_failure();
  endtask

  task automatic check_eq(string name, logic [31:0] got, logic [31:0] exp);
    assert (got == exp) else report_mismatch(name, got, exp);
  endtask

  // RV32I register arithmetic, alt selects SUB or SRA
  function automatic logic [31:0] arith(logic [2:0] f3, logic alt, logic [31:0] a,
                                        logic [31:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (f3)
      3'b000: arith = alt ? a - b : a + b;
      3'b001: arith = a << sh;
      3'b010: arith = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011: arith = (a < b) ? 32'd1 : 32'd0;
      3'b100: arith = a ^ b;
      3'b101: arith = alt ? ((a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'd0)) : a >> sh;
      3'b110: arith = a | b;
      default: arith = a & b;
    endcase
  endfunction

  function automatic logic branch_taken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
    case (f3)
      3'b000: branch_taken = a == b;
      3'b001: branch_taken = a != b;
      3'b100: branch_taken = $signed(a) < $signed(b);
      3'b101: branch_taken = $signed(a) >= $signed(b);
      3'b110: branch_taken = a < b;
      default: branch_taken = a >= b;
    endcase
  endfunction

  task automatic gen_insn(input logic last, output rv_pkg::insn_t w);
    int unsigned pick;
    logic [11:0] imm12;
    logic [19:0] imm20;
    logic [12:0] off;
    logic [4:0]  shamt;
    pick    = $urandom_range(0, 9);
    imm12   = 12'($urandom);
    imm20   = 20'($urandom);
    off     = {12'($urandom), 1'b0};
    shamt   = 5'($urandom);
    cur_rd  = 5'($urandom);
    cur_rs1 = 5'($urandom);
    cur_rs2 = 5'($urandom);
    cur_f3  = 3'($urandom);
    cur_alt = 1'b0;
    cur_imm = '0;
    w       = '0;
    if (last)
      cur_grp = G_ECALL;
    else if (pick == 0)
      cur_grp = G_LUI;
    else if (pick == 1)
      cur_grp = G_AUIPC;
    else if (pick <= 4)
      cur_grp = G_OPIMM;
    else if (pick <= 7)
      cur_grp = G_OP;
    else
      cur_grp = G_BRANCH;
    case (cur_grp)
      G_LUI, G_AUIPC:
      begin
        w.u.opcode = (cur_grp == G_LUI) ? rv_pkg::OPC_LUI : rv_pkg::OPC_AUIPC;
        w.u.rd     = cur_rd;
        w.u.imm    = imm20;
        cur_imm    = {imm20, 12'b0};
      end
      G_OPIMM:
      begin
        // shift immediates carry funct7 above shamt
        if (cur_f3 == 3'b001)
          imm12 = {rv_pkg::FUNCT7_BASE, shamt};
        if (cur_f3 == 3'b101)
        begin
          cur_alt = 1'($urandom);
          imm12   = {cur_alt ? rv_pkg::FUNCT7_ALT : rv_pkg::FUNCT7_BASE, shamt};
        end
        w.i.opcode = rv_pkg::OPC_OP_IMM;
        w.i.rd     = cur_rd;
        w.i.funct3 = cur_f3;
        w.i.rs1    = cur_rs1;
        w.i.imm    = imm12;
        cur_imm    = {{20{imm12[11]}}, imm12};
      end
      G_OP:
      begin
        if (cur_f3 == 3'b000 || cur_f3 == 3'b101)
          cur_alt = 1'($urandom);
        w.r.opcode = rv_pkg::OPC_OP;
        w.r.rd     = cur_rd;
        w.r.funct3 = cur_f3;
        w.r.rs1    = cur_rs1;
        w.r.rs2    = cur_rs2;
        w.r.funct7 = cur_alt ? rv_pkg::FUNCT7_ALT : rv_pkg::FUNCT7_BASE;
      end
      G_BRANCH:
      begin
        cur_f3       = br_f3[$urandom_range(0, 5)];
        w.b.opcode   = rv_pkg::OPC_BRANCH;
        w.b.funct3   = cur_f3;
        w.b.rs1      = cur_rs1;
        w.b.rs2      = cur_rs2;
        w.b.imm_12   = off[12];
        w.b.imm_11   = off[11];
        w.b.imm_10_5 = off[10:5];
        w.b.imm_4_1  = off[4:1];
        cur_imm      = {{19{off[12]}}, off};
      end
      default:
      begin
        // ecall, all other fields zero
        w.i.opcode = rv_pkg::OPC_SYSTEM;
      end
    endcase
  endtask

  task automatic model_expect(output logic we, output logic [31:0] data,
                              output logic [31:0] next);
    logic [31:0] a;
    logic [31:0] b;
    a    = mregs[cur_rs1];
    b    = mregs[cur_rs2];
    we   = 1'b1;
    data = '0;
    next = mpc + 32'd4;
    case (cur_grp)
      G_LUI:   data = cur_imm;
      G_AUIPC: data = mpc + cur_imm;
      G_OPIMM: data = arith(cur_f3, cur_alt, a, cur_imm);
      G_OP:    data = arith(cur_f3, cur_alt, a, b);
      G_BRANCH:
      begin
        we = 1'b0;
        if (branch_taken(cur_f3, a, b))
          next = mpc + cur_imm;
      end
      default: we = 1'b0;
    endcase
  endtask

  // registered state, sampled on the falling edge
  task automatic check_state();
    check_eq("o_pc", o_pc, mpc);
    check_eq("o_halt", 32'(o_halt), 32'(mhalt));
    check_eq("o_insn_ready", 32'(o_insn_ready), 32'(!mhalt));
  endtask

  // offer one instruction until accepted, starting at a falling edge
  task automatic issue_insn(input rv_pkg::insn_t w);
    int          waited;
    logic        accepted;
    logic        exp_we;
    logic [31:0] exp_data;
    logic [31:0] exp_next;
    waited   = 0;
    accepted = 1'b0;
    while (!accepted)
    begin
      check_state();
      i_insn       = w;
      i_insn_valid = $urandom_range(0, 3) != 0;
      // commit port is combinational, sampled well before the rising edge
      #1;
      accepted = i_insn_valid && o_insn_ready;
      check_eq("o_commit_valid", 32'(o_commit_valid), 32'(i_insn_valid && !mhalt));
      if (accepted)
      begin
        model_expect(exp_we, exp_data, exp_next);
        check_eq("o_commit.pc", o_commit.pc, mpc);
        check_eq("o_commit.next_pc", o_commit.next_pc, exp_next);
        check_eq("o_commit.rd_we", 32'(o_commit.rd_we), 32'(exp_we));
        if (exp_we)
        begin
          check_eq("o_commit.rd", 32'(o_commit.rd), 32'(cur_rd));
          check_eq("o_commit.rd_data", o_commit.rd_data, exp_data);
          if (cur_rd != 5'd0)
            mregs[cur_rd] = exp_data;
        end
        mpc   = exp_next;
        mhalt = cur_grp == G_ECALL;
      end
      @(posedge clk);
      @(negedge clk);
      waited++;
      if (!accepted && waited >= WAIT_LIMIT)
        report_timeout("instruction acceptance");
    end
  endtask

  initial
  begin
    rv_pkg::insn_t w;
    clk          = 1'b0;
    rst          = 1'b1;
    i_insn_valid = 1'b0;
    i_insn       = '0;
    void'($urandom(SEED));
    mpc   = rv_pkg::RESET_PC;
    mhalt = 1'b0;
    for (int i = 0; i < 32; i++)
      mregs[i] = '0;

    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_state();
    check_eq("o_commit_valid", 32'(o_commit_valid), 32'd0);

    for (int n = 0; n < NUM_INSNS; n++)
    begin
      gen_insn(n == NUM_INSNS - 1, w);
      issue_insn(w);
    end

    // halted core must ignore a valid instruction held at its pc
    gen_insn(1'b0, w);
    i_insn       = w;
    i_insn_valid = 1'b1;
    for (int c = 0; c < HALT_HOLD; c++)
    begin
      check_state();
      #1;
      check_eq("o_commit_valid", 32'(o_commit_valid), 32'd0);
      @(posedge clk);
      @(negedge clk);
    end
    check_state();

    $display("%0d instructions retired, core halted at pc 0x%08h", NUM_INSNS, mpc);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

//--- sources.f
rv_pkg.sv
rv_decoder.sv
rv_regfile.sv
rv_alu.sv
rv_branch_unit.sv
rv_core.sv
tb_rv_core.sv

//--- Makefile
# Verilator build and run for the rv_core testbench

VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
